// ==== filelist.f ====
+incdir+rtl
rtl/a2g_pkg.sv
rtl/bus_phase_ctrl.sv
rtl/card_response_arbiter.sv
rtl/audio_mixer.sv
rtl/scanline_dimmer.sv
rtl/a2_card_glue.sv
dv/tb_a2_card_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the card glue testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_a2_card_glue \
    --Mdir obj_dir \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_a2_card_glue 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// ==== dv/tb_a2_card_glue.sv ====
// ==============================
// Card glue testbench
// Random stimulus, reference model
// and cycle-by-cycle output checks
// ==============================

`include "a2g_defs.svh"

module tb_a2_card_glue import a2g_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int AUDIO_DIV    = 32;
    localparam int RESET_CYCLES = 3;
    localparam int N_PULSES     = 40;
    localparam int WAIT_LIMIT   = 100;

    logic      clk_logic_w;
    logic      arst_n_i;
    logic      a2_phi1_i;
    logic      ssc_rd_i, ssp_rd_i, mb_rd_i, diskii_rd_i;
    bus_data_t ssc_data_i, ssp_data_i, mb_data_i, diskii_data_i;
    logic      ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i;
    sample_t   ssp_audio_i;
    mb_level_t mb_audio_l_i, mb_audio_r_i;
    logic      speaker_i;
    logic      scanlines_en_i, pixel_y_lsb_i;
    color_t    r_i, g_i, b_i;
    logic      phi0_o, phi1_rise_o;
    bus_data_t bus_data_o;
    logic      bus_data_oe_o, irq_n_o, audio_valid_o;
    sample_t   audio_l_o, audio_r_o;
    color_t    r_o, g_o, b_o;

    // Inputs and phi0 as the model saw them one cycle earlier
    logic      p_ssc_rd, p_ssp_rd, p_mb_rd, p_dsk_rd;
    bus_data_t p_ssc_d, p_ssp_d, p_mb_d, p_dsk_d;
    logic      p_ssc_irq, p_ssp_irq, p_mb_irq;
    logic      p_phi0;
    sample_t   p_ssp_audio;
    mb_level_t p_mb_l, p_mb_r;
    logic      p_spk, p_scan_en, p_y_lsb;
    color_t    p_r, p_g, p_b;

    logic chk_en = 1'b0;
    logic phi0_was_high = 1'b0;
    logic seen_valid = 1'b0;
    int   rise_cnt = 0;
    int   audio_cnt = 0;
    int   cyc_since_valid = 0;

    a2_card_glue #(
        .AUDIO_DIV(AUDIO_DIV)
    ) a2_card_glue_inst (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #4 clk_logic_w = ~clk_logic_w;
    end

    task automatic mismatch_stop(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic error_stop(input string what);
        $display("Error: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    // Priority SuperSerial, SuperSprite, Mockingboard, Disk II
    function automatic bus_data_t pick_card_data();
        if (p_ssc_rd) return p_ssc_d;
        if (p_ssp_rd) return p_ssp_d;
        if (p_mb_rd) return p_mb_d;
        if (p_dsk_rd) return p_dsk_d;
        return '0;
    endfunction

    always @(negedge clk_logic_w) begin
        logic    exp_oe;
        sample_t exp_l;
        sample_t exp_r;
        logic    dim;
        if (chk_en) begin
            exp_oe = (p_ssc_rd | p_ssp_rd | p_mb_rd | p_dsk_rd) & p_phi0;
            assert (bus_data_oe_o == exp_oe) else mismatch_stop("bus_oe", exp_oe, bus_data_oe_o);
            assert (bus_data_o == pick_card_data())
                else mismatch_stop("bus_data", pick_card_data(), bus_data_o);
            assert (irq_n_o == (p_ssc_irq & p_ssp_irq & p_mb_irq))
                else mismatch_stop("irq_n", p_ssc_irq & p_ssp_irq & p_mb_irq, irq_n_o);

            dim = p_scan_en & p_y_lsb;
            assert (r_o == (dim ? p_r >> 1 : p_r))
                else mismatch_stop("red", dim ? p_r >> 1 : p_r, r_o);
            assert (g_o == (dim ? p_g >> 1 : p_g))
                else mismatch_stop("green", dim ? p_g >> 1 : p_g, g_o);
            assert (b_o == (dim ? p_b >> 1 : p_b))
                else mismatch_stop("blue", dim ? p_b >> 1 : p_b, b_o);

            // Phi0 may only fall together with a rise strobe
            assert (!(p_phi0 && !phi0_o) || phi1_rise_o)
                else error_stop("phi0 went low without a phi1 rise strobe");
            if (phi1_rise_o) begin
                assert (phi0_was_high && !phi0_o)
                    else error_stop("phi1 rise strobe without phi0 high since the last rise");
                phi0_was_high = 1'b0;
                rise_cnt++;
            end else if (phi0_o) begin
                phi0_was_high = 1'b1;
            end

            cyc_since_valid++;
            if (audio_valid_o) begin
                exp_l = sample_t'(32'(p_ssp_audio) + (32'(p_mb_l) << `A2G_MB_SHIFT)
                        + (32'(p_spk) << `A2G_SPK_SHIFT));
                exp_r = sample_t'(32'(p_ssp_audio) + (32'(p_mb_r) << `A2G_MB_SHIFT)
                        + (32'(p_spk) << `A2G_SPK_SHIFT));
                assert (audio_l_o == exp_l) else mismatch_stop("audio_left", exp_l, audio_l_o);
                assert (audio_r_o == exp_r) else mismatch_stop("audio_right", exp_r, audio_r_o);
                if (seen_valid) begin
                    assert (cyc_since_valid == AUDIO_DIV)
                        else mismatch_stop("audio_period", AUDIO_DIV, cyc_since_valid);
                end
                seen_valid = 1'b1;
                cyc_since_valid = 0;
                audio_cnt++;
            end
        end
        p_ssc_rd    = ssc_rd_i;
        p_ssp_rd    = ssp_rd_i;
        p_mb_rd     = mb_rd_i;
        p_dsk_rd    = diskii_rd_i;
        p_ssc_d     = ssc_data_i;
        p_ssp_d     = ssp_data_i;
        p_mb_d      = mb_data_i;
        p_dsk_d     = diskii_data_i;
        p_ssc_irq   = ssc_irq_n_i;
        p_ssp_irq   = ssp_irq_n_i;
        p_mb_irq    = mb_irq_n_i;
        p_phi0      = phi0_o;
        p_ssp_audio = ssp_audio_i;
        p_mb_l      = mb_audio_l_i;
        p_mb_r      = mb_audio_r_i;
        p_spk       = speaker_i;
        p_scan_en   = scanlines_en_i;
        p_y_lsb     = pixel_y_lsb_i;
        p_r         = r_i;
        p_g         = g_i;
        p_b         = b_i;
    end

    // One clock of fresh random traffic on every input but Phi1
    task automatic drive_cycle(input logic phi1);
        @(posedge clk_logic_w);
        a2_phi1_i      <= phi1;
        ssc_rd_i       <= ($urandom % 3) == 0;
        ssp_rd_i       <= ($urandom % 3) == 0;
        mb_rd_i        <= ($urandom % 3) == 0;
        diskii_rd_i    <= ($urandom % 3) == 0;
        ssc_data_i     <= bus_data_t'($urandom);
        ssp_data_i     <= bus_data_t'($urandom);
        mb_data_i      <= bus_data_t'($urandom);
        diskii_data_i  <= bus_data_t'($urandom);
        ssc_irq_n_i    <= ($urandom % 4) != 0;
        ssp_irq_n_i    <= ($urandom % 4) != 0;
        mb_irq_n_i     <= ($urandom % 4) != 0;
        ssp_audio_i    <= sample_t'($urandom);
        mb_audio_l_i   <= mb_level_t'($urandom);
        mb_audio_r_i   <= mb_level_t'($urandom);
        speaker_i      <= 1'($urandom);
        scanlines_en_i <= 1'($urandom);
        pixel_y_lsb_i  <= 1'($urandom);
        r_i            <= color_t'($urandom);
        g_i            <= color_t'($urandom);
        b_i            <= color_t'($urandom);
    endtask

    task automatic check_reset_outputs();
        assert (bus_data_oe_o == 1'b0) else mismatch_stop("reset_bus_oe", 0, bus_data_oe_o);
        assert (irq_n_o == 1'b1) else mismatch_stop("reset_irq_n", 1, irq_n_o);
        assert (audio_valid_o == 1'b0) else mismatch_stop("reset_audio_valid", 0, audio_valid_o);
        assert (phi1_rise_o == 1'b0) else mismatch_stop("reset_phi1_rise", 0, phi1_rise_o);
        assert (phi0_o == 1'b1) else mismatch_stop("reset_phi0", 1, phi0_o);
        assert (r_o == '0) else mismatch_stop("reset_red", 0, r_o);
        assert (g_o == '0) else mismatch_stop("reset_green", 0, g_o);
        assert (b_o == '0) else mismatch_stop("reset_blue", 0, b_o);
    endtask

    task automatic wait_rise_count(input int target);
        int waited;
        waited = 0;
        while (rise_cnt < target && waited < WAIT_LIMIT) begin
            drive_cycle(1'b0);
            waited++;
        end
        assert (rise_cnt >= target) else error_stop("timeout waiting for a phi1 rise strobe");
        assert (rise_cnt == target) else mismatch_stop("phi1_rise_count", target, rise_cnt);
    endtask

    task automatic settle_phi0_high();
        int waited;
        waited = 0;
        while (!phi0_o && waited < WAIT_LIMIT) begin
            drive_cycle(1'b0);
            waited++;
        end
        assert (phi0_o) else error_stop("timeout waiting for phi0 to return high");
    endtask

    task automatic collect_audio_pulses(input int count);
        int target;
        int waited;
        target = audio_cnt + count;
        waited = 0;
        while (audio_cnt < target && waited < (count + 1) * AUDIO_DIV) begin
            drive_cycle(1'b0);
            waited++;
        end
        assert (audio_cnt >= target) else error_stop("timeout waiting for audio_valid_o");
    endtask

    // Clean pulses with short glitches in the low gaps
    task automatic run_phase_filter();
        int p;
        int len;
        for (p = 0; p < N_PULSES; p++) begin
            len = 6 + $urandom % 7;
            repeat (len) drive_cycle(1'b0);
            len = 1 + $urandom % 2;
            repeat (len) drive_cycle(1'b1);
            len = 6 + $urandom % 7;
            repeat (len) drive_cycle(1'b0);
            len = 8 + $urandom % 33;
            repeat (len) drive_cycle(1'b1);
            wait_rise_count(p + 1);
        end
        settle_phi0_high();
    endtask

    initial begin
        int i;
        void'($urandom(32'h9d27_a85d));
        arst_n_i       = 1'b0;
        a2_phi1_i      = 1'b0;
        ssc_rd_i       = 1'b0;
        ssp_rd_i       = 1'b0;
        mb_rd_i        = 1'b0;
        diskii_rd_i    = 1'b0;
        ssc_data_i     = '0;
        ssp_data_i     = '0;
        mb_data_i      = '0;
        diskii_data_i  = '0;
        ssc_irq_n_i    = 1'b1;
        ssp_irq_n_i    = 1'b1;
        mb_irq_n_i     = 1'b1;
        ssp_audio_i    = '0;
        mb_audio_l_i   = '0;
        mb_audio_r_i   = '0;
        speaker_i      = 1'b0;
        scanlines_en_i = 1'b0;
        pixel_y_lsb_i  = 1'b0;
        r_i            = '0;
        g_i            = '0;
        b_i            = '0;

        repeat (RESET_CYCLES) begin
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            check_reset_outputs();
        end
        @(posedge clk_logic_w);
        arst_n_i <= 1'b1;
        drive_cycle(1'b0);
        chk_en <= 1'b1;

        run_phase_filter();

        // Slow Phi1 square wave so phi0 gating sees both levels
        for (i = 0; i < 400; i++) begin
            drive_cycle(1'((i / 16) % 2));
        end
        settle_phi0_high();
        collect_audio_pulses(4);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== rtl/a2_card_glue.sv ====
// ==============================
// Apple II card glue, top level
// Phase control, bus response,
// audio mix and scanline dimming
// ==============================

module a2_card_glue import a2g_pkg::*; #(
    parameter int AUDIO_DIV = 32
) (
    input  logic      clk_logic_w,
    input  logic      arst_n_i,
    input  logic      a2_phi1_i,
    input  logic      ssc_rd_i,
    input  logic      ssp_rd_i,
    input  logic      mb_rd_i,
    input  logic      diskii_rd_i,
    input  bus_data_t ssc_data_i,
    input  bus_data_t ssp_data_i,
    input  bus_data_t mb_data_i,
    input  bus_data_t diskii_data_i,
    input  logic      ssc_irq_n_i,
    input  logic      ssp_irq_n_i,
    input  logic      mb_irq_n_i,
    input  sample_t   ssp_audio_i,
    input  mb_level_t mb_audio_l_i,
    input  mb_level_t mb_audio_r_i,
    input  logic      speaker_i,
    input  logic      scanlines_en_i,
    input  logic      pixel_y_lsb_i,
    input  color_t    r_i,
    input  color_t    g_i,
    input  color_t    b_i,
    output logic      phi0_o,
    output logic      phi1_rise_o,
    output bus_data_t bus_data_o,
    output logic      bus_data_oe_o,
    output logic      irq_n_o,
    output sample_t   audio_l_o,
    output sample_t   audio_r_o,
    output logic      audio_valid_o,
    output color_t    r_o,
    output color_t    g_o,
    output color_t    b_o
);

    logic sample_stb_w;

    // Phi1 filter and audio rate
    bus_phase_ctrl #(
        .AUDIO_DIV(AUDIO_DIV)
    ) bus_phase_ctrl_inst (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .a2_phi1_i   (a2_phi1_i),
        .phi0_o      (phi0_o),
        .phi1_rise_o (phi1_rise_o),
        .phi1_fall_o (),
        .sample_stb_o(sample_stb_w)
    );

    // Slot card read data and IRQs
    card_response_arbiter card_response_arbiter_inst (
        .clk_logic_w  (clk_logic_w),
        .arst_n_i     (arst_n_i),
        .phi0_i       (phi0_o),
        .ssc_rd_i     (ssc_rd_i),
        .ssp_rd_i     (ssp_rd_i),
        .mb_rd_i      (mb_rd_i),
        .diskii_rd_i  (diskii_rd_i),
        .ssc_data_i   (ssc_data_i),
        .ssp_data_i   (ssp_data_i),
        .mb_data_i    (mb_data_i),
        .diskii_data_i(diskii_data_i),
        .ssc_irq_n_i  (ssc_irq_n_i),
        .ssp_irq_n_i  (ssp_irq_n_i),
        .mb_irq_n_i   (mb_irq_n_i),
        .bus_data_o   (bus_data_o),
        .bus_data_oe_o(bus_data_oe_o),
        .irq_n_o      (irq_n_o)
    );

    audio_mixer audio_mixer_inst (
        .clk_logic_w  (clk_logic_w),
        .arst_n_i     (arst_n_i),
        .sample_stb_i (sample_stb_w),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .speaker_i    (speaker_i),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o),
        .audio_valid_o(audio_valid_o)
    );

    // Video path is independent of the bus phase
    scanline_dimmer scanline_dimmer_inst (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .scanlines_en_i(scanlines_en_i),
        .pixel_y_lsb_i (pixel_y_lsb_i),
        .r_i           (r_i),
        .g_i           (g_i),
        .b_i           (b_i),
        .r_o           (r_o),
        .g_o           (g_o),
        .b_o           (b_o)
    );

endmodule

// ==== rtl/scanline_dimmer.sv ====
// ==============================
// Scanline dimmer
// Halves pixel colour on odd
// lines when scanlines are on
// ==============================

module scanline_dimmer import a2g_pkg::*; (
    input  logic   clk_logic_w,
    input  logic   arst_n_i,
    input  logic   scanlines_en_i,
    input  logic   pixel_y_lsb_i,
    input  color_t r_i,
    input  color_t g_i,
    input  color_t b_i,
    output color_t r_o,
    output color_t g_o,
    output color_t b_o
);

    logic dim;

    // Only odd lines get darkened
    assign dim = scanlines_en_i & pixel_y_lsb_i;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else if (dim) begin
            // Right shift by one is half brightness
            r_o <= r_i >> 1;
            g_o <= g_i >> 1;
            b_o <= b_i >> 1;
        end else begin
            r_o <= r_i;
            g_o <= g_i;
            b_o <= b_i;
        end
    end

endmodule

// ==== rtl/audio_mixer.sv ====
// ==============================
// Audio mixer
// Sums SuperSprite, Mockingboard
// and speaker into L/R samples
// ==============================

`include "a2g_defs.svh"

module audio_mixer import a2g_pkg::*; (
    input  logic      clk_logic_w,
    input  logic      arst_n_i,
    input  logic      sample_stb_i,
    input  sample_t   ssp_audio_i,
    input  mb_level_t mb_audio_l_i,
    input  mb_level_t mb_audio_r_i,
    input  logic      speaker_i,
    output sample_t   audio_l_o,
    output sample_t   audio_r_o,
    output logic      audio_valid_o
);

    sample_t mb_l_term;
    sample_t mb_r_term;
    sample_t spk_term;

    // Scale each source into the sample range
    assign mb_l_term = sample_t'(mb_audio_l_i) << `A2G_MB_SHIFT;
    assign mb_r_term = sample_t'(mb_audio_r_i) << `A2G_MB_SHIFT;
    assign spk_term  = sample_t'(speaker_i) << `A2G_SPK_SHIFT;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            audio_valid_o <= 1'b0;
        end else begin
            audio_valid_o <= sample_stb_i;
        end
    end

    // Sum wraps at the sample width
    always_ff @(posedge clk_logic_w) begin
        if (sample_stb_i) begin
            audio_l_o <= ssp_audio_i + mb_l_term + spk_term;
            audio_r_o <= ssp_audio_i + mb_r_term + spk_term;
        end
    end

    // Output samples only appear on the controller's pace
    a_valid_after_stb: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        audio_valid_o |-> $past(sample_stb_i));

endmodule

// ==== rtl/card_response_arbiter.sv ====
// ==============================
// Card response arbiter
// Merges slot card read data onto
// the bus during Phi0 and combines
// the card interrupt lines
// ==============================

module card_response_arbiter import a2g_pkg::*; (
    input  logic      clk_logic_w,
    input  logic      arst_n_i,
    input  logic      phi0_i,
    input  logic      ssc_rd_i,
    input  logic      ssp_rd_i,
    input  logic      mb_rd_i,
    input  logic      diskii_rd_i,
    input  bus_data_t ssc_data_i,
    input  bus_data_t ssp_data_i,
    input  bus_data_t mb_data_i,
    input  bus_data_t diskii_data_i,
    input  logic      ssc_irq_n_i,
    input  logic      ssp_irq_n_i,
    input  logic      mb_irq_n_i,
    output bus_data_t bus_data_o,
    output logic      bus_data_oe_o,
    output logic      irq_n_o
);

    logic      any_rd;
    bus_data_t sel_data;

    assign any_rd = ssc_rd_i | ssp_rd_i | mb_rd_i | diskii_rd_i;

    // SuperSerial first, Disk II last
    always_comb begin
        if (ssc_rd_i) begin
            sel_data = ssc_data_i;
        end else if (ssp_rd_i) begin
            sel_data = ssp_data_i;
        end else if (mb_rd_i) begin
            sel_data = mb_data_i;
        end else if (diskii_rd_i) begin
            sel_data = diskii_data_i;
        end else begin
            sel_data = '0;
        end
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_data_oe_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            // Cards may only drive the bus in Phi0
            bus_data_oe_o <= any_rd & phi0_i;
            // Open-drain style wired AND of the IRQ lines
            irq_n_o       <= ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        bus_data_o <= sel_data;
    end

    // Driving the bus outside Phi0 would clash with the 6502
    a_oe_in_phi0: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        bus_data_oe_o |-> $past(phi0_i));

endmodule

// ==== rtl/bus_phase_ctrl.sv ====
// ==============================
// Bus phase controller
// Brings Phi1 into the logic clock,
// filters glitches, derives Phi0 and
// its edges, and paces audio samples
// ==============================

`include "a2g_defs.svh"

module bus_phase_ctrl #(
    parameter int AUDIO_DIV = 32
) (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    input  logic a2_phi1_i,
    output logic phi0_o,
    output logic phi1_rise_o,
    output logic phi1_fall_o,
    output logic sample_stb_o
);

    localparam int SYNC_N = `A2G_SYNC_STAGES;
    localparam int HIST_N = `A2G_DENOISE_LEN;
    localparam int CNT_W  = (AUDIO_DIV > 1) ? $clog2(AUDIO_DIV) : 1;

    logic [SYNC_N-1:0] sync_q;
    logic [HIST_N-1:0] hist_q;
    logic              phi1_q;
    logic              hist_high;
    logic              hist_low;
    logic [CNT_W-1:0]  div_cnt_q;

    // Unanimous history decides the level
    assign hist_high = &hist_q;
    assign hist_low  = ~|hist_q;

    // Phi0 is the complement of the clean Phi1
    assign phi0_o = ~phi1_q;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q      <= '0;
            hist_q      <= '0;
            phi1_q      <= 1'b0;
            phi1_rise_o <= 1'b0;
            phi1_fall_o <= 1'b0;
        end else begin
            sync_q      <= {sync_q[SYNC_N-2:0], a2_phi1_i};
            hist_q      <= {hist_q[HIST_N-2:0], sync_q[SYNC_N-1]};
            phi1_rise_o <= 1'b0;
            phi1_fall_o <= 1'b0;
            if (hist_high && !phi1_q) begin
                phi1_q      <= 1'b1;
                phi1_rise_o <= 1'b1;
            end else if (hist_low && phi1_q) begin
                phi1_q      <= 1'b0;
                phi1_fall_o <= 1'b1;
            end
        end
    end

    // Free-running divider for the audio sample rate
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt_q    <= '0;
            sample_stb_o <= 1'b0;
        end else begin
            sample_stb_o <= (div_cnt_q == CNT_W'(AUDIO_DIV - 1));
            if (div_cnt_q == CNT_W'(AUDIO_DIV - 1)) begin
                div_cnt_q <= '0;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    // A single accepted level change per cycle
    a_edge_excl: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        !(phi1_rise_o && phi1_fall_o));

    // Strobe stays one cycle wide
    a_stb_single: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        sample_stb_o |=> !sample_stb_o);

endmodule

// ==== rtl/a2g_pkg.sv ====
// ==============================
// Apple II card glue types
// Data types shared by the glue
// ==============================

`include "a2g_defs.svh"

package a2g_pkg;

    // One byte on the Apple II data bus
    typedef logic [`A2G_DATA_W-1:0] bus_data_t;

    // Unsigned audio sample that wraps on overflow
    typedef logic [`A2G_SAMPLE_W-1:0] sample_t;

    // Output level of one Mockingboard channel
    typedef logic [`A2G_MB_W-1:0] mb_level_t;

    // Single red, green or blue channel
    typedef logic [`A2G_COLOR_W-1:0] color_t;

endpackage

// ==== rtl/a2g_defs.svh ====
// ==============================
// Apple II card glue constants
// Bus, audio and video widths,
// mixer shifts, Phi1 filter sizes
// ==============================

`ifndef A2G_DEFS_SVH
`define A2G_DEFS_SVH

// Apple II data bus
`define A2G_DATA_W 8

// Audio sample and Mockingboard level widths
`define A2G_SAMPLE_W 16
`define A2G_MB_W 10

// Scaling of the sources before they are summed
`define A2G_MB_SHIFT 5
`define A2G_SPK_SHIFT 13

// Phi1 synchronizer depth
`define A2G_SYNC_STAGES 2

// Equal samples needed before the filtered Phi1 may change
`define A2G_DENOISE_LEN 3

// One RGB colour channel
`define A2G_COLOR_W 8

`endif
